/* Bender.yml */
package:
  name: iic_master

dependencies: {}

sources:
  - hdl/iic_pkg.sv
  - hdl/iic_phase_if.sv
  - hdl/iic_phase_gen.sv
  - hdl/iic_seq_fsm.sv
  - hdl/iic_line_ctrl.sv
  - hdl/iic_master.sv
  - target: simulation
    files:
      - sim/iic_eeprom_model.sv
      - sim/tb_iic_master.sv

/* all.f */
hdl/iic_pkg.sv
hdl/iic_phase_if.sv
hdl/iic_phase_gen.sv
hdl/iic_seq_fsm.sv
hdl/iic_line_ctrl.sv
hdl/iic_master.sv
sim/iic_eeprom_model.sv
sim/tb_iic_master.sv

/* hdl/iic_line_ctrl.sv */
// drives scl and sda from the fsm position, captures read bytes and slave acknowledge errors
`timescale 1ns/1ps

module iic_line_ctrl
    import iic_pkg::*;
(
    input  logic        iic_clk,
    input  logic        iic_rst,
    input  iic_state_t  state,
    input  bit_cnt_t    bit_cnt,
    input  byte_cnt_t   byte_cnt,
    input  word_addr_t  addr_q,
    input  data_t       wdata_q,
    iic_phase_if.line   ph,
    output logic        scl,
    output logic        sda_oe,      // 0 hands sda to the slave
    output logic        sda_out,
    output data_t       rdata,
    output logic        rdata_valid,
    output logic        ack_error,
    input  logic        sda_in       // pad level
);

    int unsigned bit_pos;       // msb first position in the addr/data word
    logic        ack_bit;       // 9th bit of a byte or 10th of a start frame
    logic        data_bit;      // one of the 8 payload bits
    logic        slave_ack;     // ack slot owned by the slave
    logic        last_rd_byte;
    logic        rd_done;       // final read bit just sampled
    data_t       rd_buf;

    always_comb begin
        bit_pos  = 32'(byte_cnt) * 8 + 32'(bit_cnt);
        if (state == START_DEV || state == R_START_DEV) begin
            ack_bit = (bit_cnt == START_BITS - 1'b1);
        end else begin
            ack_bit = (bit_cnt == BYTE_BITS - 1'b1);
        end
        data_bit     = (bit_cnt < BYTE_BITS - 1'b1);
        slave_ack    = ack_bit && (state != R_DATA);      // master acks while reading
        last_rd_byte = (byte_cnt == byte_cnt_t'(DATA_BYTES - 1));
    end

    // scl held high through the start bit so sda can fall under it
    always_ff @(posedge iic_clk or negedge iic_rst) begin
        if (!iic_rst) begin
            scl <= 1'b1;
        end else if (state == IDLE || ph.scl_rise) begin
            scl <= 1'b1;
        end else if (ph.scl_fall && !(state == START_DEV && bit_cnt == '0)) begin
            scl <= 1'b0;
        end
    end

    always_ff @(posedge iic_clk or negedge iic_rst) begin
        if (!iic_rst) begin
            sda_oe  <= 1'b1;
            sda_out <= 1'b1;             // released
        end else begin
            case (state)
                IDLE: begin
                    sda_oe  <= 1'b1;
                    sda_out <= 1'b1;
                end
                START_DEV: begin
                    if (ph.sda_drive) begin
                        sda_oe <= !ack_bit;
                        if (!ack_bit) begin
                            sda_out <= START_WR_FRAME[4'd8 - bit_cnt];
                        end
                    end
                end
                R_START_DEV: begin
                    if (ph.sda_drive) begin
                        sda_oe <= !ack_bit;
                        if (!ack_bit) begin
                            sda_out <= START_RD_FRAME[4'd8 - bit_cnt];
                        end
                    end else if (ph.sda_sample && bit_cnt == '0) begin
                        sda_out <= 1'b0;     // repeated start, scl high
                    end
                end
                W_ADDR: begin
                    if (ph.sda_drive) begin
                        sda_oe <= !ack_bit;
                        if (data_bit) begin
                            sda_out <= addr_q[ADDR_BYTES*8 - 1 - bit_pos];
                        end
                    end
                end
                W_DATA: begin
                    if (ph.sda_drive) begin
                        sda_oe <= !ack_bit;
                        if (data_bit) begin
                            sda_out <= wdata_q[DATA_BYTES*8 - 1 - bit_pos];
                        end
                    end
                end
                R_DATA: begin
                    if (ph.sda_drive) begin
                        sda_oe <= ack_bit;       // slave drives data bits
                        if (ack_bit) begin
                            sda_out <= last_rd_byte; // nack ends the burst
                        end
                    end
                end
                STOP: begin
                    if (ph.sda_drive) begin
                        sda_oe  <= 1'b1;
                        sda_out <= 1'b0;         // low while scl low
                    end else if (ph.sda_sample) begin
                        sda_out <= 1'b1;         // rising under high scl
                    end
                end
                default: sda_out <= 1'b1;
            endcase
        end
    end

    always_ff @(posedge iic_clk) begin
        if (state == R_DATA && ph.sda_sample && data_bit) begin
            rd_buf[DATA_BYTES*8 - 1 - bit_pos] <= sda_in;
        end
        if (rd_done) begin
            rdata <= rd_buf;
        end
    end

    always_ff @(posedge iic_clk or negedge iic_rst) begin
        if (!iic_rst) begin
            rd_done     <= 1'b0;
            rdata_valid <= 1'b0;
        end else begin
            rd_done     <= (state == R_DATA) && ph.sda_sample && last_rd_byte
                           && (bit_cnt == BYTE_BITS - 4'd2);
            rdata_valid <= rd_done;      // lines up with rdata
        end
    end

    // sticky over the transfer, cleared during the first start bit
    always_ff @(posedge iic_clk or negedge iic_rst) begin
        if (!iic_rst) begin
            ack_error <= 1'b0;
        end else if (state == START_DEV && bit_cnt == '0) begin
            ack_error <= 1'b0;
        end else if (ph.sda_sample && slave_ack && sda_in) begin
            ack_error <= 1'b1;           // nobody pulled sda low
        end
    end

endmodule

/* hdl/iic_master.sv */
// i2c burst master top, start/ready handshake on plain ports and the open-drain sda pad
`timescale 1ns/1ps

module iic_master
    import iic_pkg::*;
(
    input  logic        iic_clk,
    input  logic        iic_rst,
    input  logic        iic_start,
    input  logic        iic_rw_flag,     // 1 read
    input  word_addr_t  iic_word_addr,
    input  data_t       iic_wdata,
    output logic        iic_ready,
    output data_t       iic_rdata,
    output logic        iic_rdata_valid,
    output logic        iic_ack_error,
    output logic        iic_scl,
    inout  wire         iic_sda
);

    logic        run;
    iic_state_t  state;
    bit_cnt_t    bit_cnt;
    byte_cnt_t   byte_cnt;
    word_addr_t  addr_q;
    data_t       wdata_q;
    logic        sda_oe;
    logic        sda_out;
    logic        sda_in;

    iic_phase_if ph_if ();

    // only ever pull low, a high level comes from the pullup
    assign iic_sda = (sda_oe && !sda_out) ? 1'b0 : 1'bz;
    assign sda_in  = iic_sda;

    iic_phase_gen u_phase_gen (
        .iic_clk (iic_clk),
        .iic_rst (iic_rst),
        .run     (run),
        .ph      (ph_if)
    );

    iic_seq_fsm u_seq_fsm (
        .iic_clk   (iic_clk),
        .iic_rst   (iic_rst),
        .start     (iic_start),
        .rw        (iic_rw_flag),
        .word_addr (iic_word_addr),
        .wdata     (iic_wdata),
        .ph        (ph_if),
        .ready     (iic_ready),
        .run       (run),
        .state     (state),
        .bit_cnt   (bit_cnt),
        .byte_cnt  (byte_cnt),
        .addr_q    (addr_q),
        .wdata_q   (wdata_q)
    );

    iic_line_ctrl u_line_ctrl (
        .iic_clk     (iic_clk),
        .iic_rst     (iic_rst),
        .state       (state),
        .bit_cnt     (bit_cnt),
        .byte_cnt    (byte_cnt),
        .addr_q      (addr_q),
        .wdata_q     (wdata_q),
        .ph          (ph_if),
        .scl         (iic_scl),
        .sda_oe      (sda_oe),
        .sda_out     (sda_out),
        .rdata       (iic_rdata),
        .rdata_valid (iic_rdata_valid),
        .ack_error   (iic_ack_error),
        .sda_in      (sda_in)
    );

endmodule

/* hdl/iic_phase_gen.sv */
// scl period counter, decodes the quarter points into strobes while the fsm is running
`timescale 1ns/1ps

module iic_phase_gen
    import iic_pkg::*;
(
    input  logic        iic_clk,
    input  logic        iic_rst,
    input  logic        run,       // high outside IDLE
    iic_phase_if.gen    ph
);

    scl_cnt_t cnt;                 // position inside the current scl period

    // free running while busy, parked at zero when idle
    always_ff @(posedge iic_clk or negedge iic_rst) begin
        if (!iic_rst) begin
            cnt <= '0;
        end else if (!run) begin
            cnt <= '0;             // first busy cycle starts at count 0
        end else if (cnt == SCL_LAST) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // period end is needed in the same cycle by the counters of the fsm
    assign ph.period_end = run && (cnt == SCL_LAST);

    // edge strobes land one cycle after their count
    always_ff @(posedge iic_clk or negedge iic_rst) begin
        if (!iic_rst) begin
            ph.scl_fall   <= 1'b0;
            ph.scl_rise   <= 1'b0;
            ph.sda_drive  <= 1'b0;
            ph.sda_sample <= 1'b0;
        end else if (!run) begin
            ph.scl_fall   <= 1'b0;  // quiet bus
            ph.scl_rise   <= 1'b0;
            ph.sda_drive  <= 1'b0;
            ph.sda_sample <= 1'b0;
        end else begin
            ph.scl_fall   <= (cnt == '0);
            ph.scl_rise   <= (cnt == SCL_RISE_PT);
            ph.sda_drive  <= (cnt == SDA_DRIVE_PT);
            ph.sda_sample <= (cnt == SDA_SAMPLE_PT);
        end
    end

endmodule

/* hdl/iic_phase_if.sv */
// quarter-period strobes of one scl period, from iic_phase_gen to the fsm and the line block
`timescale 1ns/1ps

interface iic_phase_if;

    logic period_end;   // last count of the period, comb
    logic scl_fall;     // count zero, registered
    logic scl_rise;     // half period
    logic sda_drive;    // quarter period
    logic sda_sample;   // three quarter period

    modport gen (
        output period_end, scl_fall, scl_rise, sda_drive, sda_sample
    );

    modport seq (
        input period_end
    );

    modport line (
        input scl_fall, scl_rise, sda_drive, sda_sample
    );

endinterface

/* hdl/iic_pkg.sv */
// shared widths, byte counts, bus constants and fsm states for the i2c master, import with iic_pkg::*
package iic_pkg;

    localparam int ADDR_BYTES = 1;                 // word address bytes sent after device addr
    localparam int DATA_BYTES = 2;                 // data bytes per burst
    localparam logic [6:0] DEVICE_ADDR = 7'b1010000; // eeprom slave address
    localparam int SCL_DIV = 40;                   // iic_clk cycles per scl period
    localparam int SCL_CNT_W = $clog2(SCL_DIV);

    typedef logic [ADDR_BYTES*8-1:0] word_addr_t;  // high byte goes out first
    typedef logic [DATA_BYTES*8-1:0] data_t;
    typedef logic [SCL_CNT_W-1:0]    scl_cnt_t;
    typedef logic [3:0]              bit_cnt_t;     // up to 10 bits per phase
    typedef logic [7:0]              byte_cnt_t;

    // quarter points of one scl period
    localparam scl_cnt_t SCL_LAST      = scl_cnt_t'(SCL_DIV - 1);
    localparam scl_cnt_t SCL_RISE_PT   = scl_cnt_t'((SCL_DIV - 1) / 2);     // scl goes high
    localparam scl_cnt_t SDA_DRIVE_PT  = scl_cnt_t'((SCL_DIV - 1) / 4);     // scl low, sda may move
    localparam scl_cnt_t SDA_SAMPLE_PT = scl_cnt_t'((SCL_DIV - 1) * 3 / 4); // scl high, sda stable

    // bits per phase, ack slot included
    localparam bit_cnt_t START_BITS = 4'd10;       // start + 7 addr + r/w + ack
    localparam bit_cnt_t BYTE_BITS  = 4'd9;        // 8 data + ack

    // start frames, msb sent at bit 0 of the phase
    localparam logic [8:0] START_WR_FRAME = {1'b0, DEVICE_ADDR, 1'b0}; // sda low under high scl
    // repeated start: sda released high first, pulled low at the sample point
    localparam logic [8:0] START_RD_FRAME = {1'b1, DEVICE_ADDR, 1'b1};

    typedef enum logic [2:0] {
        IDLE,
        START_DEV,     // start + device addr + write
        W_ADDR,        // word address bytes
        W_DATA,        // payload bytes, write path
        R_START_DEV,   // repeated start + device addr + read
        R_DATA,        // payload bytes, read path
        STOP
    } iic_state_t;

endpackage

/* hdl/iic_seq_fsm.sv */
// transfer sequencer: takes the start request, steps start/address/data/stop phases by bit and byte
`timescale 1ns/1ps

module iic_seq_fsm
    import iic_pkg::*;
(
    input  logic        iic_clk,
    input  logic        iic_rst,
    input  logic        start,      // one cycle request
    input  logic        rw,         // 1 read, 0 write
    input  word_addr_t  word_addr,
    input  data_t       wdata,
    iic_phase_if.seq    ph,
    output logic        ready,
    output logic        run,
    output iic_state_t  state,
    output bit_cnt_t    bit_cnt,
    output byte_cnt_t   byte_cnt,
    output word_addr_t  addr_q,
    output data_t       wdata_q
);

    logic       accept;      // start taken this cycle
    logic       rw_q;
    bit_cnt_t   bit_num;     // bits in the current phase
    byte_cnt_t  byte_num;    // bytes in the current phase
    logic       bit_end;     // last bit of a byte/frame done
    logic       byte_end;    // last byte of the phase done

    assign accept = start && ready;   // start while busy is dropped
    assign run    = (state != IDLE);

    always_comb begin
        case (state)
            START_DEV, R_START_DEV: bit_num = START_BITS;
            STOP:                   bit_num = bit_cnt_t'(1);  // single stop bit
            default:                bit_num = BYTE_BITS;
        endcase
        case (state)
            W_ADDR:         byte_num = byte_cnt_t'(ADDR_BYTES);
            W_DATA, R_DATA: byte_num = byte_cnt_t'(DATA_BYTES);
            default:        byte_num = byte_cnt_t'(1);      // frames and stop count as one
        endcase
        bit_end  = ph.period_end && (bit_cnt == bit_num - 1'b1);
        byte_end = bit_end && (byte_cnt == byte_num - 1'b1);
    end

    // busy from the cycle after accept until one cycle after IDLE is back
    always_ff @(posedge iic_clk or negedge iic_rst) begin
        if (!iic_rst) begin
            ready <= 1'b1;
        end else if (accept) begin
            ready <= 1'b0;
        end else if (state == IDLE) begin
            ready <= 1'b1;
        end
    end

    // request held for the whole transfer
    always_ff @(posedge iic_clk) begin
        if (accept) begin
            rw_q    <= rw;
            addr_q  <= word_addr;
            wdata_q <= wdata;
        end
    end

    always_ff @(posedge iic_clk or negedge iic_rst) begin
        if (!iic_rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        state <= START_DEV;
                    end
                end
                START_DEV: begin
                    if (byte_end) begin
                        state <= W_ADDR;
                    end
                end
                W_ADDR: begin
                    if (byte_end) begin
                        state <= rw_q ? R_START_DEV : W_DATA;  // read turns around here
                    end
                end
                W_DATA, R_DATA: begin
                    if (byte_end) begin
                        state <= STOP;
                    end
                end
                R_START_DEV: begin
                    if (byte_end) begin
                        state <= R_DATA;
                    end
                end
                STOP: begin
                    if (byte_end) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // bit and byte position, both restart with every phase
    always_ff @(posedge iic_clk or negedge iic_rst) begin
        if (!iic_rst) begin
            bit_cnt  <= '0;
            byte_cnt <= '0;
        end else if (state == IDLE) begin
            bit_cnt  <= '0;
            byte_cnt <= '0;
        end else if (bit_end) begin
            bit_cnt  <= '0;
            byte_cnt <= byte_end ? '0 : byte_cnt + 1'b1;
        end else if (ph.period_end) begin
            bit_cnt  <= bit_cnt + 1'b1;
        end
    end

endmodule

/* sim/iic_eeprom_model.sv */
// behavioral i2c eeprom slave for the testbench, open-drain sda, counts starts, stops and framing faults
`timescale 1ns/1ps

module iic_eeprom_model
    import iic_pkg::*;
(
    input  logic scl,
    inout  wire  sda,
    input  logic refuse_ack,       // 1 leaves every byte unacknowledged
    output int   start_count,
    output int   stop_count,
    output int   frame_errors
);

    typedef enum logic [2:0] {S_IDLE, S_DEV, S_WADDR, S_WDATA, S_READ, S_IGNORE} slave_phase_t;

    logic [7:0]   mem [0:255];     // filled by the testbench
    slave_phase_t phase;
    int           bit_idx;         // scl rises seen in the current byte
    int           addr_bytes;      // word address bytes taken so far
    logic [7:0]   shift;
    logic [7:0]   rd_byte;
    logic [7:0]   ptr;             // word pointer, wraps at 256
    logic         ack;
    logic         pull_low;
    logic         in_transfer;
    logic         scl_q;
    logic         sda_q;

    assign sda = pull_low ? 1'b0 : 1'bz;   // open drain

    initial begin
        phase        = S_IDLE;
        bit_idx      = 0;
        addr_bytes   = 0;
        ptr          = '0;
        pull_low     = 1'b0;
        in_transfer  = 1'b0;
        start_count  = 0;
        stop_count   = 0;
        frame_errors = 0;
    end

    always @(scl or sda) begin
        if (scl === 1'b1 && scl_q === 1'b1 && sda_q === 1'b1 && sda === 1'b0) begin
            if (in_transfer && bit_idx > 1) begin
                frame_errors++;            // start cut into a byte
            end
            start_count++;
            in_transfer = 1'b1;
            phase       = S_DEV;           // start or repeated start
            bit_idx     = 0;
            addr_bytes  = 0;
        end else if (scl === 1'b1 && scl_q === 1'b1 && sda_q === 1'b0 && sda === 1'b1) begin
            if (!in_transfer || bit_idx > 1) begin
                frame_errors++;            // stop with no start or mid byte
            end
            stop_count++;
            in_transfer = 1'b0;
            phase       = S_IDLE;
            bit_idx     = 0;
        end else if (scl_q === 1'b0 && scl === 1'b1 && in_transfer) begin
            if (bit_idx < 8) begin
                shift   = {shift[6:0], sda};   // msb first
                bit_idx = bit_idx + 1;
            end else begin
                bit_idx = 0;
                if (phase == S_READ && sda !== 1'b0) begin
                    phase = S_IGNORE;          // master nack ends the burst
                end
            end
        end else if (scl_q === 1'b1 && scl === 1'b0) begin
            if (!in_transfer) begin
                frame_errors++;                // clocking without a start
            end else if (bit_idx == 8) begin
                ack = 1'b0;
                case (phase)
                    S_DEV: begin
                        if (shift[7:1] == DEVICE_ADDR && !refuse_ack) begin
                            ack   = 1'b1;
                            phase = shift[0] ? S_READ : S_WADDR;
                        end else begin
                            phase = S_IGNORE;
                        end
                    end
                    S_WADDR: begin
                        ack = 1'b1;
                        ptr = shift;           // last address byte selects the word
                        addr_bytes = addr_bytes + 1;
                        if (addr_bytes == ADDR_BYTES) begin
                            phase = S_WDATA;
                        end
                    end
                    S_WDATA: begin
                        ack      = 1'b1;
                        mem[ptr] = shift;
                        ptr      = ptr + 8'd1;
                    end
                    default: ack = 1'b0;       // read ack slot is the master's
                endcase
                pull_low <= #1 ack;
            end else if (phase == S_READ) begin
                if (bit_idx == 0) begin
                    rd_byte = mem[ptr];
                    ptr     = ptr + 8'd1;
                end
                pull_low <= #1 !rd_byte[7 - bit_idx];
            end else begin
                pull_low <= #1 1'b0;           // hand sda back
            end
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

/* sim/tb_iic_master.sv */
// testbench for the i2c burst master, random reads and writes against an eeprom model and a reference memory
`timescale 1ns/1ps

module tb_iic_master
    import iic_pkg::*;
();

    localparam int     NUM_RAND    = 40;
    localparam longint WATCHDOG_NS = 64'd2 * NUM_RAND * 58 * SCL_DIV * 4;  // worst case bound

    logic       iic_clk;
    logic       iic_rst;
    logic       iic_start;
    logic       iic_rw_flag;
    word_addr_t iic_word_addr;
    data_t      iic_wdata;
    logic       iic_ready;
    data_t      iic_rdata;
    logic       iic_rdata_valid;
    logic       iic_ack_error;
    logic       iic_scl;
    wire        iic_sda;
    logic       refuse_ack;
    int         start_count;
    int         stop_count;
    int         frame_errors;

    logic [7:0]  ref_mem [0:255];
    logic [31:0] rng;
    int          errors = 0;
    int          tests = 0;
    int          failed_tests = 0;
    int          valid_count = 0;
    data_t       rdata_seen;

    pullup (iic_sda);

    iic_master DUT (
        .iic_clk         (iic_clk),
        .iic_rst         (iic_rst),
        .iic_start       (iic_start),
        .iic_rw_flag     (iic_rw_flag),
        .iic_word_addr   (iic_word_addr),
        .iic_wdata       (iic_wdata),
        .iic_ready       (iic_ready),
        .iic_rdata       (iic_rdata),
        .iic_rdata_valid (iic_rdata_valid),
        .iic_ack_error   (iic_ack_error),
        .iic_scl         (iic_scl),
        .iic_sda         (iic_sda)
    );

    iic_eeprom_model slave (
        .scl          (iic_scl),
        .sda          (iic_sda),
        .refuse_ack   (refuse_ack),
        .start_count  (start_count),
        .stop_count   (stop_count),
        .frame_errors (frame_errors)
    );

    initial begin
        iic_clk = 1'b0;
        forever #2 iic_clk = ~iic_clk;     // 4 ns period
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, a transfer never returned to ready");
        $display("Some tests failed");
        $finish;
    end

    // outputs sampled on the falling edge, clear of register updates
    always @(negedge iic_clk) begin
        if (iic_rst === 1'b1 && iic_rdata_valid === 1'b1) begin
            valid_count = valid_count + 1;
            rdata_seen  = iic_rdata;
        end
        if (iic_rst === 1'b1 && iic_ready === 1'b1) begin
            assert (iic_scl === 1'b1) else begin
                $display("ERROR scl low while the master is ready at %0t ns", $time);
                errors++;
            end
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // bytes from the address upward, first byte ends up high
    function automatic data_t expected_read(input word_addr_t addr);
        data_t      v;
        logic [7:0] a;
        int         k;
        v = '0;
        a = addr[7:0];
        for (k = 0; k < DATA_BYTES; k++) begin
            v = (v << 8) | data_t'(ref_mem[a]);
            a = a + 8'd1;                   // wraps at 256
        end
        return v;
    endfunction

    function automatic data_t model_bytes(input word_addr_t addr);
        data_t      v;
        logic [7:0] a;
        int         k;
        v = '0;
        a = addr[7:0];
        for (k = 0; k < DATA_BYTES; k++) begin
            v = (v << 8) | data_t'(slave.mem[a]);
            a = a + 8'd1;
        end
        return v;
    endfunction

    function automatic logic memories_agree();
        int k;
        for (k = 0; k < 256; k++) begin
            if (slave.mem[k] !== ref_mem[k]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic mirror_write(input word_addr_t addr, input data_t wd);
        logic [7:0] a;
        int         k;
        a = addr[7:0];
        for (k = 0; k < DATA_BYTES; k++) begin
            ref_mem[a] = wd[(DATA_BYTES - 1 - k) * 8 +: 8];   // high byte first
            a = a + 8'd1;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("MISMATCH %s expected %0h actual %0h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_true(input string name, input logic cond, input string what);
        assert (cond === 1'b1) else begin
            $display("ERROR %s: %s", name, what);
            errors++;
        end
    endtask

    task automatic close_test(input string name, input int errs_before);
        tests++;
        if (errors == errs_before) begin
            $display("%s: ok", name);
        end else begin
            failed_tests++;
            $display("%s: FAILED", name);
        end
    endtask

    // one request, optional second start while busy, back when ready rises
    task automatic run_transfer(input logic rw, input word_addr_t addr, input data_t wd,
                                input logic poke);
        @(posedge iic_clk);
        #1;
        valid_count   = 0;
        iic_start     = 1'b1;
        iic_rw_flag   = rw;
        iic_word_addr = addr;
        iic_wdata     = wd;
        @(posedge iic_clk);
        #1;
        iic_start = 1'b0;
        if (poke) begin
            repeat (100) @(posedge iic_clk);
            #1;
            iic_start     = 1'b1;           // master busy, must be dropped
            iic_rw_flag   = 1'b0;
            iic_word_addr = addr ^ word_addr_t'(8'h80);
            iic_wdata     = ~wd;
            @(posedge iic_clk);
            #1;
            iic_start = 1'b0;
        end
        @(negedge iic_clk);
        while (iic_ready !== 1'b1) @(negedge iic_clk);
    endtask

    task automatic checked_transfer(input string name, input logic rw, input word_addr_t addr,
                                    input data_t wd, input logic poke, input logic ack_err);
        int starts0;
        int stops0;
        int frames0;
        starts0 = start_count;
        stops0  = stop_count;
        frames0 = frame_errors;
        run_transfer(rw, addr, wd, poke);
        if (rw) begin
            check_value(name, 32'(expected_read(addr)), 32'(rdata_seen));
            check_value({name, " valid pulses"}, 1, valid_count);
        end else begin
            if (!ack_err) begin
                mirror_write(addr, wd);     // refused writes leave memory alone
            end
            check_value({name, " memory"}, 32'(expected_read(addr)), 32'(model_bytes(addr)));
            check_value({name, " valid pulses"}, 0, valid_count);
        end
        check_value({name, " starts"}, rw ? 2 : 1, start_count - starts0);
        check_value({name, " stops"}, 1, stop_count - stops0);
        check_value({name, " framing faults"}, 0, frame_errors - frames0);
        check_value({name, " ack_error"}, 32'(ack_err), 32'(iic_ack_error));
    endtask

    initial begin : main_seq
        int         k;
        int         e0;
        string      name;
        logic       rw;
        word_addr_t addr;
        data_t      wd;
        rng           = 32'hedee6564;
        iic_rst       = 1'b0;
        iic_start     = 1'b0;
        iic_rw_flag   = 1'b0;
        iic_word_addr = '0;
        iic_wdata     = '0;
        refuse_ack    = 1'b0;
        for (k = 0; k < 256; k++) begin
            ref_mem[k]   = 8'(k * 7 + 3);   // odd stride touches every address bit
            slave.mem[k] = ref_mem[k];
        end
        repeat (2) @(posedge iic_clk);
        #1;
        iic_rst = 1'b1;

        e0 = errors;
        @(negedge iic_clk);
        check_true("reset_state", iic_ready, "ready is low after reset");
        check_true("reset_state", iic_scl, "scl is low after reset");
        check_true("reset_state", iic_sda === 1'b1, "sda is not released after reset");
        check_true("reset_state", !iic_ack_error, "ack_error is set after reset");
        check_true("reset_state", !iic_rdata_valid, "rdata_valid is set after reset");
        close_test("reset_state", e0);

        for (k = 0; k < NUM_RAND; k++) begin
            e0   = errors;
            rng  = xorshift(rng);
            rw   = rng[0];
            addr = word_addr_t'(rng >> 8);
            rng  = xorshift(rng);
            wd   = data_t'(rng);
            name = $sformatf("rand_%0d_%s", k, rw ? "rd" : "wr");
            checked_transfer(name, rw, addr, wd, 1'b0, 1'b0);
            close_test(name, e0);
        end

        e0   = errors;
        rng  = xorshift(rng);
        addr = word_addr_t'(rng >> 8);
        wd   = data_t'(xorshift(rng));
        checked_transfer("busy_start", 1'b0, addr, wd, 1'b1, 1'b0);
        check_true("busy_start", memories_agree(), "model memory differs from reference");
        checked_transfer("busy_start_readback", 1'b1, addr ^ word_addr_t'(8'h80), '0,
                         1'b0, 1'b0);
        close_test("busy_start", e0);

        e0         = errors;
        rng        = xorshift(rng);
        addr       = word_addr_t'(rng >> 16);
        wd         = data_t'(rng);
        refuse_ack = 1'b1;
        checked_transfer("refused_write", 1'b0, addr, wd, 1'b0, 1'b1);
        refuse_ack = 1'b0;
        checked_transfer("refused_readback", 1'b1, addr, '0, 1'b0, 1'b0);  // flag cleared
        close_test("refused_ack", e0);

        $display("tests run %0d, failed %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0 && failed_tests == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
